// File: source/gat_consts.svh
// Aggregator width constants
`ifndef GAT_CONSTS_SVH
`define GAT_CONSTS_SVH

// Raw input word.
`define GAT_WORD_W 16

// Header fields.
`define GAT_ID_W 12
`define GAT_DEG_W 4

// Coefficient, signed Q1.7.
`define GAT_COEF_W 8

// Neighbor feature, signed Q4.4.
`define GAT_FEAT_W 8

// Product width, signed Q5.11.
`define GAT_PROD_W (`GAT_COEF_W + `GAT_FEAT_W)

// Accumulator, signed Q9.11.
`define GAT_ACC_INT 9
`define GAT_ACC_FRAC 11
`define GAT_ACC_W (`GAT_ACC_INT + `GAT_ACC_FRAC)

// Result, signed Q4.4.
`define GAT_OUT_INT 4
`define GAT_OUT_FRAC 4
`define GAT_OUT_W (`GAT_OUT_INT + `GAT_OUT_FRAC)

`endif

// File: source/gat_pkg.sv
// Aggregator word types
`default_nettype none

`include "gat_consts.svh"

package gat_pkg;

	// Header view of an input word.
	typedef struct packed {
		logic [`GAT_ID_W-1:0]  node_id;
		logic [`GAT_DEG_W-1:0] degree;
	} node_hdr_t;

	// Data view of an input word.
	// Both fields are two's complement.
	typedef struct packed {
		logic [`GAT_COEF_W-1:0] coef;
		logic [`GAT_FEAT_W-1:0] feat;
	} node_data_t;

	// One stream word, decoded by position in the node.
	typedef union packed {
		node_hdr_t  hdr;
		node_data_t data;
	} node_word_u;

endpackage

`default_nettype wire

// File: source/aggr_ctrl_if.sv
// Aggregator control bundle
`timescale 1ns/1ps
`default_nettype none

`include "gat_consts.svh"

interface aggr_ctrl_if;

	logic                  clear;
	logic                  load;
	logic [`GAT_DEG_W-1:0] degree;
	logic                  accumulate;
	logic                  last;
	logic                  capture;

	// Sequencer side.
	modport fsm (
		output clear, load, degree, accumulate, capture,
		input  last
	);

	// Neighbor count side.
	modport counter (
		input  load, degree, accumulate,
		output last
	);

	// Arithmetic side.
	modport datapath (
		input clear, accumulate, capture
	);

endinterface

`default_nettype wire

// File: source/fxp_zoom.sv
// Fixed-point width converter
`timescale 1ns/1ps
`default_nettype none

module fxp_zoom #(
	parameter int WII   = 8,
	parameter int WIF   = 8,
	parameter int WOI   = 8,
	parameter int WOF   = 8,
	parameter int ROUND = 1
) (
	input  logic [WII+WIF-1:0] in,
	output logic [WOI+WOF-1:0] out,
	output logic               overflow
);

	localparam int WIN  = WII + WIF;
	localparam int WMID = WII + WOF;

	// Input integer part with the output fraction width.
	logic [WMID-1:0] inr;
	logic [WII-1:0]  ini;
	logic [WOF-1:0]  inf;
	logic [WOI-1:0]  outi;
	logic [WOF-1:0]  outf;

	// Fraction alignment.
	generate
		if (WOF < WIF) begin : g_frac_narrow
			if (ROUND == 0) begin : g_trunc
				assign inr = in[WIN-1:WIF-WOF];
			end else begin : g_round
				// Largest positive value, which must not wrap on round up.
				localparam logic [WMID-1:0] MAX_POS = {WMID{1'b1}} >> 1;

				always_comb begin
					inr = in[WIN-1:WIF-WOF];
					if (in[WIF-WOF-1] && (inr != MAX_POS)) begin
						inr = inr + 1'b1;
					end
				end
			end
		end else if (WOF == WIF) begin : g_frac_same
			assign inr = in;
		end else begin : g_frac_wide
			assign inr = {in, {(WOF-WIF){1'b0}}};
		end
	endgenerate

	assign {ini, inf} = inr;

	// Integer range, with saturation when it shrinks.
	generate
		if (WOI < WII) begin : g_int_narrow
			always_comb begin
				outi = ini[WOI-1:0];
				outf = inf;
				overflow = 1'b0;
				if (!ini[WII-1] && (|ini[WII-2:WOI-1])) begin
					// Above the positive limit.
					overflow = 1'b1;
					outi = {1'b0, {(WOI-1){1'b1}}};
					outf = {WOF{1'b1}};
				end else if (ini[WII-1] && !(&ini[WII-2:WOI-1])) begin
					// Below the negative limit.
					overflow = 1'b1;
					outi = {1'b1, {(WOI-1){1'b0}}};
					outf = '0;
				end
			end
		end else begin : g_int_wide
			always_comb begin
				outi = WOI'($signed(ini));
				outf = inf;
				overflow = 1'b0;
			end
		end
	endgenerate

	assign out = {outi, outf};

endmodule

`default_nettype wire

// File: source/neighbor_counter.sv
// Remaining neighbor counter
`timescale 1ns/1ps
`default_nettype none

`include "gat_consts.svh"

module neighbor_counter (
	input logic         clk,
	input logic         reset,
	aggr_ctrl_if.counter ctrl
);

	// Data words still expected for the current node.
	logic [`GAT_DEG_W-1:0] count;

	always_ff @(posedge clk) begin
		if (reset) begin
			count <= '0;
		end else if (ctrl.load) begin
			count <= ctrl.degree;
		end else if (ctrl.accumulate && (count != '0)) begin
			count <= count - 1'b1;
		end
	end

	// One word left, so the next accepted word ends the node.
	assign ctrl.last = (count == `GAT_DEG_W'(1));

endmodule

`default_nettype wire

// File: source/aggr_fsm.sv
// Node sequencing FSM
`timescale 1ns/1ps
`default_nettype none

`include "gat_consts.svh"

module aggr_fsm
	import gat_pkg::*;
(
	input  logic                clk,
	input  logic                reset,
	input  logic                in_valid,
	input  node_word_u          in_word,
	aggr_ctrl_if.fsm            ctrl,
	output logic [`GAT_ID_W-1:0] out_node
);

	localparam logic [1:0] IDLE   = 2'd0;
	localparam logic [1:0] DATA   = 2'd1;
	localparam logic [1:0] RESULT = 2'd2;

	logic [1:0]            state;
	logic [1:0]            state_next;
	logic                  hdr_ok;
	logic [`GAT_ID_W-1:0]  node_id;

	// A header only counts in IDLE, and degree zero is dropped.
	assign hdr_ok = in_valid && (state == IDLE) && (in_word.hdr.degree != '0);

	assign ctrl.clear      = hdr_ok;
	assign ctrl.load       = hdr_ok;
	assign ctrl.degree     = in_word.hdr.degree;
	assign ctrl.accumulate = in_valid && (state == DATA);
	assign ctrl.capture    = (state == RESULT);

	always_comb begin
		state_next = state;
		case (state)
			IDLE: begin
				if (hdr_ok) begin
					state_next = DATA;
				end
			end
			DATA: begin
				if (ctrl.accumulate && ctrl.last) begin
					state_next = RESULT;
				end
			end
			default: begin
				state_next = IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state    <= IDLE;
			node_id  <= '0;
			out_node <= '0;
		end else begin
			state <= state_next;
			if (hdr_ok) begin
				node_id <= in_word.hdr.node_id;
			end
			// Published together with the datapath result.
			if (ctrl.capture) begin
				out_node <= node_id;
			end
		end
	end

endmodule

`default_nettype wire

// File: source/fxp_mac.sv
// Multiply-accumulate datapath
`timescale 1ns/1ps
`default_nettype none

`include "gat_consts.svh"

module fxp_mac
	import gat_pkg::*;
(
	input  logic                 clk,
	input  logic                 reset,
	input  node_word_u           in_word,
	aggr_ctrl_if.datapath        ctrl,
	output logic                 out_valid,
	output logic [`GAT_OUT_W-1:0] out_value,
	output logic                 out_overflow
);

	logic signed [`GAT_PROD_W-1:0] product;
	logic signed [`GAT_ACC_W-1:0]  acc;
	logic [`GAT_OUT_W-1:0]         zoom_value;
	logic                          zoom_overflow;

	// Q1.7 times Q4.4 gives Q5.11.
	assign product = $signed(in_word.data.coef) * $signed(in_word.data.feat);

	always_ff @(posedge clk) begin
		if (reset || ctrl.clear) begin
			acc <= '0;
		end else if (ctrl.accumulate) begin
			acc <= acc + `GAT_ACC_W'(product);
		end
	end

	// Q9.11 down to Q4.4.
	fxp_zoom #(
		.WII   (`GAT_ACC_INT),
		.WIF   (`GAT_ACC_FRAC),
		.WOI   (`GAT_OUT_INT),
		.WOF   (`GAT_OUT_FRAC),
		.ROUND (1)
	) fxp_zoom_inst (
		.in       (acc),
		.out      (zoom_value),
		.overflow (zoom_overflow)
	);

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid    <= 1'b0;
			out_value    <= '0;
			out_overflow <= 1'b0;
		end else begin
			out_valid <= ctrl.capture;
			if (ctrl.capture) begin
				out_value    <= zoom_value;
				out_overflow <= zoom_overflow;
			end
		end
	end

endmodule

`default_nettype wire

// File: source/gat_aggregator.sv
// Neighbor aggregation top
`timescale 1ns/1ps
`default_nettype none

`include "gat_consts.svh"

module gat_aggregator (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  in_valid,
	input  logic [`GAT_WORD_W-1:0] in_word,
	output logic                  out_valid,
	output logic [`GAT_ID_W-1:0]   out_node,
	output logic [`GAT_OUT_W-1:0]  out_value,
	output logic                  out_overflow
);

	// Control between sequencer, counter and datapath.
	aggr_ctrl_if ctrl_if ();

	aggr_fsm aggr_fsm_inst (
		.clk      (clk),
		.reset    (reset),
		.in_valid (in_valid),
		.in_word  (in_word),
		.ctrl     (ctrl_if.fsm),
		.out_node (out_node)
	);

	neighbor_counter neighbor_counter_inst (
		.clk   (clk),
		.reset (reset),
		.ctrl  (ctrl_if.counter)
	);

	// Same word, read as coefficient and feature.
	fxp_mac fxp_mac_inst (
		.clk          (clk),
		.reset        (reset),
		.in_word      (in_word),
		.ctrl         (ctrl_if.datapath),
		.out_valid    (out_valid),
		.out_value    (out_value),
		.out_overflow (out_overflow)
	);

endmodule

`default_nettype wire

// File: verification/gat_aggregator_sva.sv
// Aggregator protocol assertions
`timescale 1ns/1ps
`default_nettype none

module gat_aggregator_sva (
	input logic clk,
	input logic reset,
	input logic out_valid,
	input logic capture
);

	// A result is a single-cycle strobe.
	property single_strobe;
		@(posedge clk) disable iff (reset)
		out_valid |=> !out_valid;
	endproperty

	// Nothing is reported while reset is held.
	property quiet_in_reset;
		@(posedge clk)
		reset |=> !out_valid;
	endproperty

	// Every result follows a capture cycle of the FSM.
	property follows_capture;
		@(posedge clk) disable iff (reset)
		out_valid |-> $past(capture);
	endproperty

	single_strobe_a: assert property (single_strobe)
		else $error("out_valid high for two cycles in a row");

	quiet_in_reset_a: assert property (quiet_in_reset)
		else $error("out_valid high during reset");

	follows_capture_a: assert property (follows_capture)
		else $error("out_valid without a capture in the previous cycle");

endmodule

`default_nettype wire

// File: verification/gat_aggregator_tb.sv
// Aggregator testbench
`timescale 1ns/1ps
`default_nettype none

`include "gat_consts.svh"

module gat_aggregator_tb
	import gat_pkg::*;
();

	localparam int N_NODES    = 12;
	localparam int MAX_DEG    = 15;
	localparam int WAIT_LIMIT = 100;
	localparam int LATENCY    = 2;
	localparam int SHIFT      = `GAT_ACC_FRAC - `GAT_OUT_FRAC;
	// Largest value of the accumulator after the shift.
	localparam int MID_MAX    = (1 << (`GAT_ACC_INT + `GAT_OUT_FRAC - 1)) - 1;

	logic                   clk;
	logic                   reset;
	logic                   in_valid;
	logic [`GAT_WORD_W-1:0] in_word;
	logic                   out_valid;
	logic [`GAT_ID_W-1:0]   out_node;
	logic [`GAT_OUT_W-1:0]  out_value;
	logic                   out_overflow;

	integer seed;
	integer result_count;

	// Node table with expected results.
	logic [`GAT_ID_W-1:0]   tbl_id    [N_NODES];
	logic [`GAT_DEG_W-1:0]  tbl_deg   [N_NODES];
	logic [`GAT_COEF_W-1:0] tbl_coef  [N_NODES][MAX_DEG];
	logic [`GAT_FEAT_W-1:0] tbl_feat  [N_NODES][MAX_DEG];
	logic [`GAT_OUT_W-1:0]  tbl_value [N_NODES];
	logic                   tbl_ovf   [N_NODES];

	gat_aggregator gat_aggregator_inst (
		.clk          (clk),
		.reset        (reset),
		.in_valid     (in_valid),
		.in_word      (in_word),
		.out_valid    (out_valid),
		.out_node     (out_node),
		.out_value    (out_value),
		.out_overflow (out_overflow)
	);

	bind gat_aggregator gat_aggregator_sva gat_aggregator_sva_inst (
		.clk       (clk),
		.reset     (reset),
		.out_valid (out_valid),
		.capture   (ctrl_if.capture)
	);

	always #5 clk = ~clk;

	always @(posedge clk) begin
		if (reset) begin
			result_count <= 0;
		end else if (out_valid) begin
			result_count <= result_count + 1;
		end
	end

	task automatic check_value(input string what, input integer actual, input integer expected);
		if (actual !== expected) begin
			$display("** Error at %0d ns: %s is %0d, expected %0d",
				$time, what, actual, expected);
			$display("test failed");
			$fatal(1);
		end
	endtask

	// Exact sum of products at scale 2**11.
	function automatic integer node_sum(input integer idx);
		integer sum;
		integer c;
		integer f;
		sum = 0;
		for (int k = 0; k < tbl_deg[idx]; k++) begin
			c = $signed(tbl_coef[idx][k]);
			f = $signed(tbl_feat[idx][k]);
			sum = sum + c * f;
		end
		return sum;
	endfunction

	// Round half up, then clamp to Q4.4.
	function automatic logic [8:0] round_saturate(input integer sum);
		integer q;
		q = sum >>> SHIFT;
		if (sum[SHIFT-1] && (q != MID_MAX)) begin
			q = q + 1;
		end
		if (q > 127) begin
			return {1'b1, 8'h7F};
		end else if (q < -128) begin
			return {1'b1, 8'h80};
		end
		return {1'b0, q[7:0]};
	endfunction

	task automatic set_node(input integer idx, input integer id, input integer deg,
			input integer value, input logic ovf);
		tbl_id[idx]    = id;
		tbl_deg[idx]   = deg;
		tbl_value[idx] = value;
		tbl_ovf[idx]   = ovf;
	endtask

	task automatic fill_random(input integer idx, input integer id);
		integer r;
		r = $random(seed);
		tbl_id[idx]  = id;
		tbl_deg[idx] = `GAT_DEG_W'(1 + ($unsigned(r) % 15));
		for (int k = 0; k < MAX_DEG; k++) begin
			r = $random(seed);
			tbl_coef[idx][k] = r[7:0];
			tbl_feat[idx][k] = r[15:8];
		end
		{tbl_ovf[idx], tbl_value[idx]} = round_saturate(node_sum(idx));
	endtask

	task automatic build_table();
		for (int i = 0; i < N_NODES; i++) begin
			for (int k = 0; k < MAX_DEG; k++) begin
				tbl_coef[i][k] = '0;
				tbl_feat[i][k] = '0;
			end
		end
		// 0.5 times 3.0.
		set_node(0, 'h001, 1, 24, 1'b0);
		{tbl_coef[0][0], tbl_feat[0][0]} = 16'h4030;
		set_node(1, 'h0A5, 4, 121, 1'b0);
		{tbl_coef[1][0], tbl_feat[1][0]} = 16'h2010;
		{tbl_coef[1][1], tbl_feat[1][1]} = 16'hF028;
		{tbl_coef[1][2], tbl_feat[1][2]} = 16'h7F7F;
		{tbl_coef[1][3], tbl_feat[1][3]} = 16'h10E0;
		// Saturation at both ends.
		set_node(2, 'h7FF, 15, 'h7F, 1'b1);
		set_node(3, 'h800, 8, 'h80, 1'b1);
		for (int k = 0; k < MAX_DEG; k++) begin
			{tbl_coef[2][k], tbl_feat[2][k]} = 16'h7F7F;
			{tbl_coef[3][k], tbl_feat[3][k]} = 16'h807F;
		end
		// Exact halves of both signs.
		set_node(4, 'h123, 1, 1, 1'b0);
		{tbl_coef[4][0], tbl_feat[4][0]} = 16'h0140;
		set_node(5, 'h124, 2, 'hE0, 1'b0);
		{tbl_coef[5][0], tbl_feat[5][0]} = 16'hFF40;
		{tbl_coef[5][1], tbl_feat[5][1]} = 16'h40C0;
		// 127.5 rounds up into saturation.
		set_node(6, 'h125, 3, 'h7F, 1'b1);
		{tbl_coef[6][0], tbl_feat[6][0]} = 16'h7F7F;
		{tbl_coef[6][1], tbl_feat[6][1]} = 16'h017F;
		{tbl_coef[6][2], tbl_feat[6][2]} = 16'h0140;
		// Dropped header.
		set_node(7, 'h0FF, 0, 0, 1'b0);
		for (int i = 8; i < N_NODES; i++) begin
			fill_random(i, 'h456 + i);
		end
	endtask

	task automatic drive_word(input node_word_u w);
		@(posedge clk);
		in_valid <= 1'b1;
		in_word  <= w;
	endtask

	task automatic drive_idle(input integer n);
		repeat (n) begin
			@(posedge clk);
			in_valid <= 1'b0;
		end
	endtask

	// Counts edges from the last data word to out_valid.
	task automatic wait_result(input integer node, output integer edges);
		logic seen;
		seen  = 1'b0;
		edges = 0;
		while (!seen) begin
			@(posedge clk);
			in_valid <= 1'b0;
			edges = edges + 1;
			@(negedge clk);
			seen = out_valid;
			if (!seen && (edges >= WAIT_LIMIT)) begin
				$display("Timeout waiting for out_valid of table entry %0d", node);
				$display("test failed");
				$fatal(1);
			end
		end
	endtask

	initial begin
		node_word_u w;
		integer     edges;
		integer     expected_results;
		seed             = 1442;
		clk              = 1'b0;
		reset            = 1'b1;
		in_valid         = 1'b0;
		in_word          = '0;
		expected_results = 0;
		build_table();
		repeat (16) @(posedge clk);
		reset <= 1'b0;
		drive_idle(2);
		for (int i = 0; i < N_NODES; i++) begin
			w.hdr.node_id = tbl_id[i];
			w.hdr.degree  = tbl_deg[i];
			drive_word(w);
			if (tbl_deg[i] == 0) begin
				// No result may appear for an empty node.
				for (int c = 0; c < 6; c++) begin
					drive_idle(1);
					@(negedge clk);
					check_value("out_valid after degree 0 header", out_valid, 0);
				end
			end else begin
				for (int k = 0; k < tbl_deg[i]; k++) begin
					drive_idle($random(seed) & 3);
					w.data.coef = tbl_coef[i][k];
					w.data.feat = tbl_feat[i][k];
					drive_word(w);
				end
				wait_result(i, edges);
				check_value("result latency", edges, LATENCY);
				check_value("out_node", out_node, tbl_id[i]);
				check_value("out_value", out_value, tbl_value[i]);
				check_value("out_overflow", out_overflow, tbl_ovf[i]);
				expected_results = expected_results + 1;
			end
		end
		drive_idle(4);
		check_value("number of results", result_count, expected_results);
		$display("test passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: all.f
+incdir+source
source/gat_pkg.sv
source/aggr_ctrl_if.sv
source/fxp_zoom.sv
source/neighbor_counter.sv
source/aggr_fsm.sv
source/fxp_mac.sv
source/gat_aggregator.sv
verification/gat_aggregator_sva.sv
verification/gat_aggregator_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
TOP       ?= gat_aggregator_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The log decides pass or fail.
run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "^test passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
